/* design/ext_periph_pkg.sv */
// External peripheral package
// Address map, register offsets, sizes and register-bus types shared by
// the hub, the GPIO edge counter and the interfaced FIFO
package ext_periph_pkg;

  // basic words
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [11:0] reg_offset_t;

  // counter and fifo widths
  typedef logic [11:0] cnt_t;
  typedef logic [3:0]  fifo_cnt_t;

  // external interrupt lines
  typedef logic [1:0]  intr_vec_t;

  // host side request, a one-cycle strobe with no handshake
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_req_t;

  // request as seen by a single peripheral
  typedef struct packed {
    logic        valid;
    logic        write;
    reg_offset_t offset;
    data_t       wdata;
  } periph_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } reg_rsp_t;

  // address map, one 4 KiB window per peripheral
  localparam int unsigned PERIPH_WIN_BITS = 12;
  localparam addr_t GPIO_CNT_BASE = 32'h0000_0000;
  localparam addr_t IFFIFO_BASE   = 32'h0000_1000;

  // sizes
  localparam int unsigned CNT_MAX       = 2048;
  localparam int unsigned FIFO_DEPTH    = 8;
  localparam int unsigned FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

  // gpio counter registers
  localparam reg_offset_t GPIO_CNT_COUNT_OFS = 12'h000;
  localparam reg_offset_t GPIO_CNT_WRAPS_OFS = 12'h004;
  localparam reg_offset_t GPIO_CNT_CLEAR_OFS = 12'h008;

  // iffifo registers
  localparam reg_offset_t IFFIFO_DATA_IN_OFS  = 12'h000;
  localparam reg_offset_t IFFIFO_DATA_OUT_OFS = 12'h004;
  localparam reg_offset_t IFFIFO_STATUS_OFS   = 12'h008;
  localparam reg_offset_t IFFIFO_WMARK_OFS    = 12'h00C;

  // interrupt vector positions
  localparam int unsigned INTR_GPIO_CNT_BIT = 0;
  localparam int unsigned INTR_IFFIFO_BIT   = 1;

endpackage

/* design/gpio_cnt.sv */
// GPIO edge counter
// Counts rising edges on an asynchronous input, pulses gpio_o on wrap and
// holds a sticky interrupt until software clears it
`timescale 1ns/1ps

module gpio_cnt (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  ext_periph_pkg::periph_req_t req_i,
  output ext_periph_pkg::reg_rsp_t    rsp_o,
  input  logic                        gpio_i,
  output logic                        gpio_o,
  output logic                        intr_o
);

  logic [1:0]            sync_q;
  logic                  gpio_d_q;
  logic                  rise;
  logic                  clear_req;
  logic                  wrap_event;
  ext_periph_pkg::cnt_t  count_q;
  ext_periph_pkg::data_t wraps_q;
  logic                  pending_q;
  logic                  pulse_q;

  // two-flop synchronizer, third flop for the edge detect
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q   <= '0;
      gpio_d_q <= 1'b0;
    end else begin
      sync_q   <= {sync_q[0], gpio_i};
      gpio_d_q <= sync_q[1];
    end
  end

  assign rise      = sync_q[1] & ~gpio_d_q;
  assign clear_req = req_i.valid & req_i.write &
                     (req_i.offset == ext_periph_pkg::GPIO_CNT_CLEAR_OFS);

  // last edge before CNT_MAX brings the count back to zero
  assign wrap_event = rise & ~clear_req &
                      (count_q == ext_periph_pkg::cnt_t'(ext_periph_pkg::CNT_MAX - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      wraps_q   <= '0;
      pending_q <= 1'b0;
      pulse_q   <= 1'b0;
    end else begin
      pulse_q <= wrap_event;
      if (clear_req) begin
        count_q   <= '0;
        wraps_q   <= '0;
        pending_q <= 1'b0;
      end else if (wrap_event) begin
        count_q   <= '0;
        wraps_q   <= wraps_q + 32'd1;
        pending_q <= 1'b1;
      end else if (rise) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // register read side, clear is write-only
  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.error = 1'b0;
    case (req_i.offset)
      ext_periph_pkg::GPIO_CNT_COUNT_OFS: begin
        if (req_i.write) rsp_o.error = 1'b1;
        else rsp_o.rdata = ext_periph_pkg::data_t'(count_q);
      end
      ext_periph_pkg::GPIO_CNT_WRAPS_OFS: begin
        if (req_i.write) rsp_o.error = 1'b1;
        else rsp_o.rdata = wraps_q;
      end
      ext_periph_pkg::GPIO_CNT_CLEAR_OFS: rsp_o.error = ~req_i.write;
      default: rsp_o.error = 1'b1;
    endcase
  end

  assign gpio_o = pulse_q;
  assign intr_o = pending_q;

endmodule

/* design/iffifo.sv */
// Interfaced FIFO (IFFIFO)
// Register-accessed word FIFO with a watermark interrupt; its not-full and
// not-empty levels serve as DMA trigger slots
`timescale 1ns/1ps

module iffifo (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  ext_periph_pkg::periph_req_t req_i,
  output ext_periph_pkg::reg_rsp_t    rsp_o,
  output logic                        in_ready_o,
  output logic                        out_valid_o,
  output logic                        intr_o
);

  ext_periph_pkg::data_t mem_q [ext_periph_pkg::FIFO_DEPTH];

  logic [ext_periph_pkg::FIFO_PTR_BITS-1:0] wr_ptr_q;
  logic [ext_periph_pkg::FIFO_PTR_BITS-1:0] rd_ptr_q;
  ext_periph_pkg::fifo_cnt_t                occ_q;
  ext_periph_pkg::fifo_cnt_t                wmark_q;

  logic empty;
  logic full;
  logic wr_acc;
  logic rd_acc;
  logic push;
  logic pop;
  logic wmark_wr;

  assign empty = (occ_q == '0);
  assign full  = (occ_q == ext_periph_pkg::fifo_cnt_t'(ext_periph_pkg::FIFO_DEPTH));

  assign wr_acc = req_i.valid & req_i.write;
  assign rd_acc = req_i.valid & ~req_i.write;

  // a push to a full fifo or a pop from an empty one does nothing
  assign push     = wr_acc & (req_i.offset == ext_periph_pkg::IFFIFO_DATA_IN_OFS) & ~full;
  assign pop      = rd_acc & (req_i.offset == ext_periph_pkg::IFFIFO_DATA_OUT_OFS) & ~empty;
  assign wmark_wr = wr_acc & (req_i.offset == ext_periph_pkg::IFFIFO_WMARK_OFS);

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      occ_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        occ_q    <= occ_q + 1'b1;
      end else if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        occ_q    <= occ_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wmark_q <= '0;
    end else if (wmark_wr) begin
      wmark_q <= req_i.wdata[3:0];
    end
  end

  // register response
  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.error = 1'b0;
    case (req_i.offset)
      ext_periph_pkg::IFFIFO_DATA_IN_OFS: begin
        rsp_o.error = ~req_i.write | full;
      end
      ext_periph_pkg::IFFIFO_DATA_OUT_OFS: begin
        if (req_i.write || empty) rsp_o.error = 1'b1;
        else rsp_o.rdata = mem_q[rd_ptr_q];
      end
      ext_periph_pkg::IFFIFO_STATUS_OFS: begin
        if (req_i.write) rsp_o.error = 1'b1;
        else rsp_o.rdata = {24'd0, occ_q, 2'b00, full, empty};
      end
      ext_periph_pkg::IFFIFO_WMARK_OFS: begin
        if (!req_i.write) rsp_o.rdata = ext_periph_pkg::data_t'(wmark_q);
      end
      default: rsp_o.error = 1'b1;
    endcase
  end

  // dma slot levels
  assign in_ready_o  = ~full;
  assign out_valid_o = ~empty;

  // watermark of zero disables the interrupt
  assign intr_o = (wmark_q != '0) && (occ_q >= wmark_q);

endmodule

/* design/ext_periph_hub.sv */
// External peripheral hub
// Decodes the host register bus into the two peripheral windows, muxes the
// responses back and collects the interrupt lines
`timescale 1ns/1ps

module ext_periph_hub (
  input  ext_periph_pkg::reg_req_t    reg_req_i,
  output ext_periph_pkg::reg_rsp_t    reg_rsp_o,
  output ext_periph_pkg::periph_req_t gpio_cnt_req_o,
  input  ext_periph_pkg::reg_rsp_t    gpio_cnt_rsp_i,
  output ext_periph_pkg::periph_req_t iffifo_req_o,
  input  ext_periph_pkg::reg_rsp_t    iffifo_rsp_i,
  input  logic                        gpio_cnt_intr_i,
  input  logic                        iffifo_intr_i,
  output ext_periph_pkg::intr_vec_t   intr_vector_o
);

  logic                        gpio_cnt_sel;
  logic                        iffifo_sel;
  ext_periph_pkg::reg_offset_t win_offset;

  // window match on the bits above the 4 KiB offset
  assign gpio_cnt_sel =
    (reg_req_i.addr[31:ext_periph_pkg::PERIPH_WIN_BITS] ==
     ext_periph_pkg::GPIO_CNT_BASE[31:ext_periph_pkg::PERIPH_WIN_BITS]);
  assign iffifo_sel =
    (reg_req_i.addr[31:ext_periph_pkg::PERIPH_WIN_BITS] ==
     ext_periph_pkg::IFFIFO_BASE[31:ext_periph_pkg::PERIPH_WIN_BITS]);

  assign win_offset = reg_req_i.addr[ext_periph_pkg::PERIPH_WIN_BITS-1:0];

  // demux, only the selected peripheral sees valid
  always_comb begin
    gpio_cnt_req_o.valid  = reg_req_i.valid & gpio_cnt_sel;
    gpio_cnt_req_o.write  = reg_req_i.write;
    gpio_cnt_req_o.offset = win_offset;
    gpio_cnt_req_o.wdata  = reg_req_i.wdata;

    iffifo_req_o.valid  = reg_req_i.valid & iffifo_sel;
    iffifo_req_o.write  = reg_req_i.write;
    iffifo_req_o.offset = win_offset;
    iffifo_req_o.wdata  = reg_req_i.wdata;
  end

  // response mux, unmapped addresses get an error with zero data
  always_comb begin
    if (gpio_cnt_sel) begin
      reg_rsp_o = gpio_cnt_rsp_i;
    end else if (iffifo_sel) begin
      reg_rsp_o = iffifo_rsp_i;
    end else begin
      reg_rsp_o.rdata = '0;
      reg_rsp_o.error = 1'b1;
    end
  end

  always_comb begin
    intr_vector_o = '0;
    intr_vector_o[ext_periph_pkg::INTR_GPIO_CNT_BIT] = gpio_cnt_intr_i;
    intr_vector_o[ext_periph_pkg::INTR_IFFIFO_BIT]   = iffifo_intr_i;
  end

endmodule

/* design/ext_periph_subsystem.sv */
// External peripheral subsystem
// Register bus hub with the GPIO edge counter and the IFFIFO behind it
`timescale 1ns/1ps

module ext_periph_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ext_periph_pkg::reg_req_t  reg_req_i,
  output ext_periph_pkg::reg_rsp_t  reg_rsp_o,
  input  logic                      gpio_i,
  output logic                      gpio_o,
  output logic                      dma_slot_tx_o,
  output logic                      dma_slot_rx_o,
  output ext_periph_pkg::intr_vec_t intr_vector_o
);

  ext_periph_pkg::periph_req_t gpio_cnt_req;
  ext_periph_pkg::reg_rsp_t    gpio_cnt_rsp;
  ext_periph_pkg::periph_req_t iffifo_req;
  ext_periph_pkg::reg_rsp_t    iffifo_rsp;
  logic                        gpio_cnt_intr;
  logic                        iffifo_intr;

  ext_periph_hub u_hub (
    .reg_req_i       (reg_req_i),
    .reg_rsp_o       (reg_rsp_o),
    .gpio_cnt_req_o  (gpio_cnt_req),
    .gpio_cnt_rsp_i  (gpio_cnt_rsp),
    .iffifo_req_o    (iffifo_req),
    .iffifo_rsp_i    (iffifo_rsp),
    .gpio_cnt_intr_i (gpio_cnt_intr),
    .iffifo_intr_i   (iffifo_intr),
    .intr_vector_o   (intr_vector_o)
  );

  gpio_cnt u_gpio_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (gpio_cnt_req),
    .rsp_o   (gpio_cnt_rsp),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .intr_o  (gpio_cnt_intr)
  );

  // fifo levels drive the dma trigger slots
  iffifo u_iffifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (iffifo_req),
    .rsp_o       (iffifo_rsp),
    .in_ready_o  (dma_slot_tx_o),
    .out_valid_o (dma_slot_rx_o),
    .intr_o      (iffifo_intr)
  );

endmodule

/* test/tb_clk_gen.sv */
// Testbench clock and reset generator
// 8 ns clock, reset held low for the first two cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int unsigned HALF_PERIOD = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* test/tb_reg_tasks.svh */
// Register bus tasks and reference models for the peripheral testbench
// Each access is a one-cycle strobe launched on the falling clock edge

// expected peripheral state
ext_periph_pkg::data_t     fifo_model [$];
ext_periph_pkg::fifo_cnt_t wmark_model;
int unsigned               edge_model;
int unsigned               wraps_model;
logic                      pending_model;

function automatic ext_periph_pkg::addr_t cnt_addr(input ext_periph_pkg::reg_offset_t ofs);
  return ext_periph_pkg::GPIO_CNT_BASE | ext_periph_pkg::addr_t'(ofs);
endfunction

function automatic ext_periph_pkg::addr_t fifo_addr(input ext_periph_pkg::reg_offset_t ofs);
  return ext_periph_pkg::IFFIFO_BASE | ext_periph_pkg::addr_t'(ofs);
endfunction

// response is captured in the low phase, before the edge that commits it
task automatic reg_access(input ext_periph_pkg::addr_t addr, input logic write,
                          input ext_periph_pkg::data_t wdata,
                          output ext_periph_pkg::data_t rdata, output logic err);
  @(negedge clk);
  reg_req.valid = 1'b1;
  reg_req.write = write;
  reg_req.addr  = addr;
  reg_req.wdata = wdata;
  #(SAMPLE_DELAY);
  rdata = reg_rsp.rdata;
  err   = reg_rsp.error;
  @(negedge clk);
  reg_req = '0;
endtask

task automatic reg_write(input ext_periph_pkg::addr_t addr, input ext_periph_pkg::data_t data,
                         output logic err);
  ext_periph_pkg::data_t ignored;
  reg_access(addr, 1'b1, data, ignored, err);
endtask

task automatic reg_read(input ext_periph_pkg::addr_t addr, output ext_periph_pkg::data_t data,
                        output logic err);
  reg_access(addr, 1'b0, '0, data, err);
endtask

// status word: empty at bit 0, full at bit 1, occupancy at 7:4
function automatic ext_periph_pkg::data_t fifo_status_model();
  int   occ;
  logic empty;
  logic full;
  occ   = fifo_model.size();
  empty = (occ == 0);
  full  = (occ == int'(ext_periph_pkg::FIFO_DEPTH));
  return {24'd0, occ[3:0], 2'b00, full, empty};
endfunction

// zero watermark never fires
function automatic logic fifo_intr_model();
  return (wmark_model != '0) && (fifo_model.size() >= int'(wmark_model));
endfunction

function automatic void count_edge();
  if (edge_model == ext_periph_pkg::CNT_MAX - 1) begin
    edge_model    = 0;
    wraps_model   = wraps_model + 1;
    pending_model = 1'b1;
  end else begin
    edge_model = edge_model + 1;
  end
endfunction

/* test/tb_ext_periph.sv */
// Testbench for the external peripheral subsystem
// Drives the register bus and the GPIO input and checks against reference models
`timescale 1ns/1ps

module tb_ext_periph;

  localparam int unsigned CLK_PERIOD      = 8;
  localparam int unsigned SAMPLE_DELAY    = 2;
  localparam int unsigned CHECK_DELAY     = 1;
  localparam int unsigned RAND_SEED       = 32'h6084_2dcb;
  localparam int unsigned MIN_RAND_PULSES = 5;
  localparam int unsigned MAX_RAND_PULSES = 40;
  localparam int unsigned PULSE_CYCLES    = 8;
  localparam int unsigned WMARK_ROUNDS    = 12;
  localparam int unsigned ACCESS_BUDGET   = 400;
  // all pulses and two-cycle accesses with a margin of two
  localparam int unsigned WATCHDOG_CYCLES =
    2 * ((ext_periph_pkg::CNT_MAX + MAX_RAND_PULSES) * PULSE_CYCLES + 2 * ACCESS_BUDGET);

  logic                      clk;
  logic                      rst_n;
  ext_periph_pkg::reg_req_t  reg_req;
  ext_periph_pkg::reg_rsp_t  reg_rsp;
  logic                      gpio_in;
  logic                      gpio_out;
  logic                      slot_tx;
  logic                      slot_rx;
  ext_periph_pkg::intr_vec_t intr_vector;
  int unsigned               gpio_pulse_count;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ext_periph_subsystem u_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .reg_req_i     (reg_req),
    .reg_rsp_o     (reg_rsp),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .dma_slot_tx_o (slot_tx),
    .dma_slot_rx_o (slot_rx),
    .intr_vector_o (intr_vector)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string signal, input logic [31:0] expected,
                                 input logic [31:0] actual);
    abort_run($sformatf("CHECK FAILED at time %0t: %s expected 0x%08h actual 0x%08h",
                        $time, signal, expected, actual));
  endtask

  `include "tb_reg_tasks.svh"

  task automatic expect_read(input ext_periph_pkg::addr_t addr, input string name,
                             input ext_periph_pkg::data_t exp_data, input logic exp_err);
    ext_periph_pkg::data_t rdata;
    logic                  err;
    reg_read(addr, rdata, err);
    assert (err == exp_err)
      else report_mismatch($sformatf("reg_rsp_o.error (%s read)", name),
                           32'(exp_err), 32'(err));
    assert (rdata == exp_data)
      else report_mismatch($sformatf("reg_rsp_o.rdata (%s read)", name), exp_data, rdata);
  endtask

  task automatic expect_write(input ext_periph_pkg::addr_t addr, input string name,
                              input ext_periph_pkg::data_t data, input logic exp_err);
    logic err;
    reg_write(addr, data, err);
    assert (err == exp_err)
      else report_mismatch($sformatf("reg_rsp_o.error (%s write)", name),
                           32'(exp_err), 32'(err));
  endtask

  // a push into a full fifo is refused and the word is lost
  task automatic fifo_push(input ext_periph_pkg::data_t data);
    logic exp_err;
    exp_err = (fifo_model.size() == int'(ext_periph_pkg::FIFO_DEPTH));
    expect_write(fifo_addr(ext_periph_pkg::IFFIFO_DATA_IN_OFS), "DATA_IN", data, exp_err);
    if (!exp_err) fifo_model.push_back(data);
  endtask

  task automatic fifo_pop();
    ext_periph_pkg::data_t exp_data;
    logic                  exp_err;
    exp_err  = (fifo_model.size() == 0);
    exp_data = exp_err ? '0 : fifo_model[0];
    expect_read(fifo_addr(ext_periph_pkg::IFFIFO_DATA_OUT_OFS), "DATA_OUT", exp_data, exp_err);
    if (!exp_err) exp_data = fifo_model.pop_front();
  endtask

  task automatic clear_counter();
    expect_write(cnt_addr(ext_periph_pkg::GPIO_CNT_CLEAR_OFS), "CLEAR", '0, 1'b0);
    edge_model    = 0;
    wraps_model   = 0;
    pending_model = 1'b0;
  endtask

  // driven from a falling edge, half of each pulse period high and half low
  task automatic drive_gpio_pulses(input int unsigned count);
    repeat (count) begin
      gpio_in = 1'b1;
      repeat (PULSE_CYCLES / 2) @(negedge clk);
      gpio_in = 1'b0;
      repeat (PULSE_CYCLES / 2) @(negedge clk);
      count_edge();
    end
  endtask

  // dma slots and fifo interrupt against the model on every cycle
  always @(negedge clk) begin
    logic exp_tx;
    logic exp_rx;
    logic exp_intr;
    #(CHECK_DELAY);
    exp_tx   = (fifo_model.size() != int'(ext_periph_pkg::FIFO_DEPTH));
    exp_rx   = (fifo_model.size() != 0);
    exp_intr = fifo_intr_model();
    if (rst_n) begin
      assert (slot_tx == exp_tx)
        else report_mismatch("dma_slot_tx_o", 32'(exp_tx), 32'(slot_tx));
      assert (slot_rx == exp_rx)
        else report_mismatch("dma_slot_rx_o", 32'(exp_rx), 32'(slot_rx));
      assert (intr_vector[ext_periph_pkg::INTR_IFFIFO_BIT] == exp_intr)
        else report_mismatch("intr_vector_o[1]", 32'(exp_intr),
                             32'(intr_vector[ext_periph_pkg::INTR_IFFIFO_BIT]));
    end
  end

  always @(negedge clk) begin
    if (rst_n && gpio_out) gpio_pulse_count = gpio_pulse_count + 1;
  end

  gpio_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) gpio_out |=> !gpio_out)
    else abort_run("gpio_o stayed high for more than one cycle");

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("timeout: the test sequence did not finish in the expected time");
  end

  initial begin
    ext_periph_pkg::data_t wm;
    int unsigned           target;
    int unsigned           n_pulses;

    reg_req          = '0;
    gpio_in          = 1'b0;
    gpio_pulse_count = 0;
    wmark_model      = '0;
    edge_model       = 0;
    wraps_model      = 0;
    pending_model    = 1'b0;
    void'($urandom(RAND_SEED));
    wait (rst_n === 1'b1);
    @(negedge clk);

    // reset state
    assert (gpio_out == 1'b0) else report_mismatch("gpio_o", 32'd0, 32'(gpio_out));
    assert (intr_vector == '0) else report_mismatch("intr_vector_o", 32'd0, 32'(intr_vector));
    assert (slot_rx == 1'b0) else report_mismatch("dma_slot_rx_o", 32'd0, 32'(slot_rx));
    assert (slot_tx == 1'b1) else report_mismatch("dma_slot_tx_o", 32'd1, 32'(slot_tx));
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_COUNT_OFS), "COUNT", '0, 1'b0);
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_WRAPS_OFS), "WRAPS", '0, 1'b0);
    expect_read(fifo_addr(ext_periph_pkg::IFFIFO_WMARK_OFS), "WMARK", '0, 1'b0);

    // decode errors
    expect_read(32'h0000_2000, "unmapped", '0, 1'b1);
    expect_read(32'hF000_0004, "unmapped", '0, 1'b1);
    expect_write(32'h0000_2000, "unmapped", 32'hDEAD_BEEF, 1'b1);
    expect_read(cnt_addr(12'h010), "gpio_cnt 0x010", '0, 1'b1);
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_CLEAR_OFS), "CLEAR", '0, 1'b1);
    expect_read(fifo_addr(12'h0FC), "iffifo 0x0FC", '0, 1'b1);
    expect_write(fifo_addr(ext_periph_pkg::IFFIFO_STATUS_OFS), "STATUS", 32'h0000_00F3, 1'b1);
    expect_read(fifo_addr(ext_periph_pkg::IFFIFO_STATUS_OFS), "STATUS", fifo_status_model(), 1'b0);

    // fill one past full and drain one past empty
    repeat (ext_periph_pkg::FIFO_DEPTH + 1) begin
      fifo_push(ext_periph_pkg::data_t'($urandom()));
      expect_read(fifo_addr(ext_periph_pkg::IFFIFO_STATUS_OFS), "STATUS",
                  fifo_status_model(), 1'b0);
    end
    repeat (ext_periph_pkg::FIFO_DEPTH + 1) begin
      fifo_pop();
      expect_read(fifo_addr(ext_periph_pkg::IFFIFO_STATUS_OFS), "STATUS",
                  fifo_status_model(), 1'b0);
    end

    // random watermarks against random occupancies
    repeat (WMARK_ROUNDS) begin
      wm     = ext_periph_pkg::data_t'($urandom_range(9, 0));
      target = $urandom_range(ext_periph_pkg::FIFO_DEPTH, 0);
      expect_write(fifo_addr(ext_periph_pkg::IFFIFO_WMARK_OFS), "WMARK", wm, 1'b0);
      wmark_model = wm[3:0];
      expect_read(fifo_addr(ext_periph_pkg::IFFIFO_WMARK_OFS), "WMARK", wm, 1'b0);
      while (fifo_model.size() < int'(target)) fifo_push(ext_periph_pkg::data_t'($urandom()));
      while (fifo_model.size() > int'(target)) fifo_pop();
    end
    while (fifo_model.size() > 0) fifo_pop();

    // edge counting and a refused write to the read-only count
    n_pulses = $urandom_range(MAX_RAND_PULSES, MIN_RAND_PULSES);
    drive_gpio_pulses(n_pulses);
    repeat (3) @(negedge clk);
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_COUNT_OFS), "COUNT", edge_model, 1'b0);
    expect_write(cnt_addr(ext_periph_pkg::GPIO_CNT_COUNT_OFS), "COUNT", 32'h0000_0FFF, 1'b1);
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_COUNT_OFS), "COUNT", edge_model, 1'b0);
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_WRAPS_OFS), "WRAPS", wraps_model, 1'b0);
    assert (gpio_pulse_count == 0)
      else report_mismatch("gpio_o pulse count", 32'd0, gpio_pulse_count);
    clear_counter();
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_COUNT_OFS), "COUNT", edge_model, 1'b0);

    // full wrap with the pending interrupt held until the clear
    drive_gpio_pulses(ext_periph_pkg::CNT_MAX);
    repeat (3) @(negedge clk);
    assert (gpio_pulse_count == 1)
      else report_mismatch("gpio_o pulse count", 32'd1, gpio_pulse_count);
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_COUNT_OFS), "COUNT", edge_model, 1'b0);
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_WRAPS_OFS), "WRAPS", wraps_model, 1'b0);
    repeat (4) begin
      @(negedge clk);
      assert (intr_vector[ext_periph_pkg::INTR_GPIO_CNT_BIT] == pending_model)
        else report_mismatch("intr_vector_o[0]", 32'(pending_model),
                             32'(intr_vector[ext_periph_pkg::INTR_GPIO_CNT_BIT]));
    end
    clear_counter();
    assert (intr_vector[ext_periph_pkg::INTR_GPIO_CNT_BIT] == pending_model)
      else report_mismatch("intr_vector_o[0]", 32'(pending_model),
                           32'(intr_vector[ext_periph_pkg::INTR_GPIO_CNT_BIT]));
    expect_read(cnt_addr(ext_periph_pkg::GPIO_CNT_WRAPS_OFS), "WRAPS", wraps_model, 1'b0);

    $display("Verification passed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+test
design/ext_periph_pkg.sv
design/gpio_cnt.sv
design/iffifo.sv
design/ext_periph_hub.sv
design/ext_periph_subsystem.sv
test/tb_clk_gen.sv
test/tb_ext_periph.sv

/* run.sh */
#!/bin/sh
# build and run the peripheral testbench with Verilator
# exits non-zero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_ext_periph

verilator --binary --timing --assert -f flist.f --top-module "$TOP" \
  -Mdir obj_dir -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi
